// File: all.f
+incdir+verilog
verilog/soc_bus_pkg.sv
verilog/soc_ctrl_pkg.sv
verilog/dw_upsizer.sv
verilog/soc_bus.sv
verilog/l2_mem.sv
verilog/cluster_fsm.sv
verilog/run_timer.sv
verilog/soc_top.sv
sim/tb_soc_top.sv

// File: run.sh
#!/bin/sh
# build and run the soc_top testbench with Verilator, verdict comes from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_soc_top \
  -o sim_soc || { echo "BUILD FAILED"; exit 1; }
./obj_dir/sim_soc > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "SIMULATION FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "SIMULATION ENDED EARLY"; exit 1; }
echo "SIMULATION PASSED"
exit 0

// File: sim/tb_soc_top.sv
// Testbench for soc_top, drives host, debug and cluster traffic while assertions check the answers
`include "soc_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;

  // tests take about 200 cycles, the limit leaves a wide margin
  localparam int MAX_CYCLES = 2000;
  localparam int RESP_WAIT  = 8;
  localparam int N_WORDS    = 16;
  localparam int IDX_W      = $clog2(`SOC_L2_WORDS);

  typedef logic [IDX_W-1:0] idx_t;

  logic                      clk_i;
  logic                      reset_i;
  logic                      host_req_valid_i;
  soc_bus_pkg::bus_req_t     host_req_i;
  soc_bus_pkg::data_t        host_rdata_o;
  logic                      host_rvalid_o;
  logic                      dbg_req_valid_i;
  soc_bus_pkg::narrow_req_t  dbg_req_i;
  soc_bus_pkg::narrow_data_t dbg_rdata_o;
  logic                      dbg_rvalid_o;
  logic                      cl_fetch_en_i;
  logic                      cl_busy_o;
  logic                      cl_eoc_o;

  // reference copy of L2 and the values expected back
  soc_bus_pkg::data_t        model [`SOC_L2_WORDS];
  idx_t                      used_idx [N_WORDS];
  soc_bus_pkg::data_t        host_exp;
  soc_bus_pkg::data_t        host_exp_q;
  soc_bus_pkg::narrow_data_t dbg_exp;
  logic                      host_rd;
  logic                      dbg_rd_alone;
  logic                      collide;
  logic                      collide_q;
  int                        busy_len;
  int                        errors;
  int                        tests;
  int                        cycles;

  soc_top dut (
    .clk_i,
    .reset_i,
    .host_req_valid_i,
    .host_req_i,
    .host_rdata_o,
    .host_rvalid_o,
    .dbg_req_valid_i,
    .dbg_req_i,
    .dbg_rdata_o,
    .dbg_rvalid_o,
    .cl_fetch_en_i,
    .cl_busy_o,
    .cl_eoc_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  assign host_rd      = host_req_valid_i && !host_req_i.write;
  assign dbg_rd_alone = dbg_req_valid_i && !dbg_req_i.write && !host_req_valid_i;
  assign collide      = dbg_req_valid_i && !dbg_req_i.write && host_req_valid_i;

  always @(posedge clk_i) begin
    host_exp_q <= host_exp;
    collide_q  <= collide;
    busy_len   <= cl_busy_o ? busy_len + 1 : 0;
  end

  task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("[FAIL] %0t %s expected %0h actual %0h", $time, sig, exp_v, act_v);
    errors++;
  endtask

  task automatic count_failure(input string msg);
    $display("%0t: %s", $time, msg);
    errors++;
  endtask

  a_reset_quiet: assert property (@(posedge clk_i)
    $fell(reset_i) |-> !host_rvalid_o && !dbg_rvalid_o && !cl_busy_o && !cl_eoc_o)
    else count_failure("strobes or cluster outputs not low after reset");
  a_host_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
    host_rd |=> host_rvalid_o)
    else report_mismatch("host_rvalid_o", 1, 0);
  a_host_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    !host_rd |=> !host_rvalid_o)
    else report_mismatch("host_rvalid_o", 0, 1);
  a_host_rdata: assert property (@(posedge clk_i) disable iff (reset_i)
    host_rd |=> host_rdata_o == host_exp_q)
    else begin
      $display("[FAIL] %0t host_rdata_o expected %h actual %h", $time,
               $sampled(host_exp_q), $sampled(host_rdata_o));
      errors++;
    end
  a_dbg_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
    dbg_rd_alone |=> dbg_rvalid_o)
    else report_mismatch("dbg_rvalid_o", 1, 0);
  // a debug read that lost to the host answers one cycle late
  a_dbg_held: assert property (@(posedge clk_i) disable iff (reset_i)
    collide |=> !dbg_rvalid_o)
    else report_mismatch("dbg_rvalid_o", 0, 1);
  a_dbg_late: assert property (@(posedge clk_i) disable iff (reset_i)
    collide_q |=> dbg_rvalid_o)
    else report_mismatch("dbg_rvalid_o", 1, 0);
  a_dbg_rdata: assert property (@(posedge clk_i) disable iff (reset_i)
    dbg_rvalid_o |-> dbg_rdata_o == dbg_exp)
    else begin
      $display("[FAIL] %0t dbg_rdata_o expected %h actual %h", $time,
               $sampled(dbg_exp), $sampled(dbg_rdata_o));
      errors++;
    end
  a_busy_start: assert property (@(posedge clk_i) disable iff (reset_i)
    cl_fetch_en_i && !cl_busy_o && !cl_eoc_o |=> cl_busy_o)
    else report_mismatch("cl_busy_o", 1, 0);
  a_busy_len: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(cl_busy_o) |-> busy_len == `SOC_CL_RUN_CYCLES)
    else begin
      $display("[FAIL] %0t cl_busy_o length expected %0d actual %0d", $time,
               `SOC_CL_RUN_CYCLES, $sampled(busy_len));
      errors++;
    end
  a_eoc_rise: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(cl_busy_o) |-> cl_eoc_o)
    else report_mismatch("cl_eoc_o", 1, 0);
  a_eoc_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    cl_eoc_o && cl_fetch_en_i |=> cl_eoc_o)
    else report_mismatch("cl_eoc_o", 1, 0);
  a_eoc_fall: assert property (@(posedge clk_i) disable iff (reset_i)
    cl_eoc_o && !cl_fetch_en_i |=> !cl_eoc_o)
    else report_mismatch("cl_eoc_o", 0, 1);

  // word index in the upper bits, address bit 2 picks the debug lane
  function automatic soc_bus_pkg::addr_t word_addr(input idx_t idx, input logic lane);
    return soc_bus_pkg::addr_t'({idx, lane, 2'b00});
  endfunction

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic host_write(input idx_t idx, input soc_bus_pkg::data_t data);
    host_req_valid_i = 1'b1;
    host_req_i.write = 1'b1;
    host_req_i.addr  = word_addr(idx, 1'b0);
    host_req_i.data  = data;
    host_req_i.strb  = '1;
    model[idx] = data;
    step();
    host_req_valid_i = 1'b0;
  endtask

  task automatic drive_host_read(input idx_t idx);
    host_exp         = model[idx];
    host_req_valid_i = 1'b1;
    host_req_i.write = 1'b0;
    host_req_i.addr  = word_addr(idx, 1'b0);
  endtask

  task automatic drive_dbg(input logic write, input idx_t idx, input logic lane,
                           input soc_bus_pkg::narrow_data_t data);
    dbg_req_valid_i = 1'b1;
    dbg_req_i.write = write;
    dbg_req_i.addr  = word_addr(idx, lane);
    dbg_req_i.data  = data;
    if (write && lane) model[idx][63:32] = data;
    else if (write) model[idx][31:0] = data;
    else dbg_exp = lane ? model[idx][63:32] : model[idx][31:0];
  endtask

  task automatic wait_dbg_resp();
    int n;
    n = 0;
    while (!dbg_rvalid_o && n < RESP_WAIT) begin
      step();
      n++;
    end
    if (!dbg_rvalid_o) begin
      $display("%0t: debug read got no response", $time);
      errors++;
    end
    step();
  endtask

  task automatic cluster_run();
    int n;
    n = 0;
    cl_fetch_en_i = 1'b1;
    while (!cl_eoc_o && n < `SOC_CL_RUN_CYCLES + 8) begin
      step();
      n++;
    end
    if (!cl_eoc_o) begin
      $display("%0t: cluster run never reported end of computation", $time);
      errors++;
    end
    step();
    step();
    cl_fetch_en_i = 1'b0;
    step();
    step();
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %0d (%s) finished, %0d failures", tests, name, errors - err_before);
  endtask

  initial begin
    int   i;
    int   err0;
    idx_t d_idx;
    void'($urandom(32));
    errors           = 0;
    tests            = 0;
    host_req_valid_i = 1'b0;
    host_req_i       = '0;
    dbg_req_valid_i  = 1'b0;
    dbg_req_i        = '0;
    cl_fetch_en_i    = 1'b0;
    host_exp         = '0;
    dbg_exp          = '0;
    reset_i          = 1'b1;
    repeat (10) @(posedge clk_i);
    #1 reset_i = 1'b0;
    step();

    err0 = errors;
    for (i = 0; i < N_WORDS; i++) begin
      used_idx[i] = idx_t'($urandom);
      host_write(used_idx[i], {$urandom, $urandom});
    end
    for (i = 0; i < N_WORDS; i++) begin
      drive_host_read(used_idx[i]);
      step();
    end
    host_req_valid_i = 1'b0;
    step();
    end_test("host write and read", err0);

    err0 = errors;
    d_idx = idx_t'($urandom);
    drive_dbg(1'b1, d_idx, 1'b0, $urandom);
    step();
    drive_dbg(1'b1, d_idx, 1'b1, $urandom);
    step();
    dbg_req_valid_i = 1'b0;
    drive_host_read(d_idx);
    step();
    host_req_valid_i = 1'b0;
    step();
    for (i = 0; i < 2; i++) begin
      drive_dbg(1'b0, d_idx, i[0], '0);
      step();
      dbg_req_valid_i = 1'b0;
      wait_dbg_resp();
    end
    end_test("debug lanes merge", err0);

    // host and debug in the same cycle, host wins
    err0 = errors;
    for (i = 0; i < 2; i++) begin
      drive_host_read(used_idx[i]);
      drive_dbg(1'b0, d_idx, i[0], '0);
      step();
      host_req_valid_i = 1'b0;
      dbg_req_valid_i  = 1'b0;
      wait_dbg_resp();
    end
    end_test("host and debug collision", err0);

    err0 = errors;
    cluster_run();
    end_test("cluster run", err0);

    err0 = errors;
    cluster_run();
    end_test("second cluster run", err0);

    step();
    step();
    $display("tests run %0d, failed checks %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, the run did not complete", MAX_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/cluster_fsm.sv
// Cluster control sequencer, turns fetch enable into busy and end of computation
`timescale 1ns/1ps
`default_nettype none

module cluster_fsm (
  input  logic clk_i,
  input  logic reset_i,
  input  logic fetch_en_i,
  input  logic expired_i,
  output logic timer_load_o,
  output logic busy_o,
  output logic eoc_o
);

  soc_ctrl_pkg::cl_state_e state_q;
  soc_ctrl_pkg::cl_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      soc_ctrl_pkg::IDLE: if (fetch_en_i) state_d = soc_ctrl_pkg::RUN;
      soc_ctrl_pkg::RUN:  if (expired_i) state_d = soc_ctrl_pkg::DONE;
      // eoc held until the host drops fetch enable
      soc_ctrl_pkg::DONE: if (!fetch_en_i) state_d = soc_ctrl_pkg::IDLE;
      default:            state_d = soc_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= soc_ctrl_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // timer starts on the same edge that enters RUN
  assign timer_load_o = (state_q == soc_ctrl_pkg::IDLE) && fetch_en_i;
  assign busy_o       = (state_q == soc_ctrl_pkg::RUN);
  assign eoc_o        = (state_q == soc_ctrl_pkg::DONE);

  a_busy_eoc_excl: assert property (
    @(posedge clk_i) disable iff (reset_i) !(busy_o && eoc_o)
  );

endmodule

`default_nettype wire

// File: verilog/dw_upsizer.sv
// Debug port width converter, widens 32-bit accesses onto the 64-bit SoC bus
`include "soc_config.svh"
`timescale 1ns/1ps
`default_nettype none

module dw_upsizer (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      dbg_req_valid_i,
  input  soc_bus_pkg::narrow_req_t  dbg_req_i,
  input  logic                      served_i,
  input  soc_bus_pkg::data_t        rdata_i,
  input  logic                      rvalid_i,
  output logic                      req_valid_o,
  output soc_bus_pkg::bus_req_t     req_o,
  output soc_bus_pkg::narrow_data_t dbg_rdata_o,
  output logic                      dbg_rvalid_o
);

  localparam int unsigned LANE_BYTES = `SOC_NARROW_W / 8;
  localparam int unsigned LANE_BIT   = $clog2(LANE_BYTES);

  soc_bus_pkg::bus_req_t wide_req;
  soc_bus_pkg::bus_req_t pend_req_q;
  logic                  pend_q;
  logic                  rd_q;
  logic                  lane_q;

  // replicate the word, strobes pick the lane
  always_comb begin
    wide_req.write = dbg_req_i.write;
    wide_req.addr  = dbg_req_i.addr;
    wide_req.data  = {dbg_req_i.data, dbg_req_i.data};
    if (dbg_req_i.addr[LANE_BIT]) begin
      wide_req.strb = {{LANE_BYTES{1'b1}}, {LANE_BYTES{1'b0}}};
    end else begin
      wide_req.strb = {{LANE_BYTES{1'b0}}, {LANE_BYTES{1'b1}}};
    end
  end

  // a held request goes out before anything new
  assign req_valid_o = pend_q | dbg_req_valid_i;
  assign req_o       = pend_q ? pend_req_q : wide_req;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q <= 1'b0;
    end else if (pend_q) begin
      if (served_i) pend_q <= 1'b0;
    end else if (dbg_req_valid_i && !served_i) begin
      pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!pend_q && dbg_req_valid_i) pend_req_q <= wide_req;
  end

  // track the served read so the right half comes back
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= served_i && !req_o.write;
    end
  end

  always_ff @(posedge clk_i) begin
    if (served_i) lane_q <= req_o.addr[LANE_BIT];
  end

  assign dbg_rdata_o  = rdata_i[lane_q*`SOC_NARROW_W +: `SOC_NARROW_W];
  assign dbg_rvalid_o = rvalid_i & rd_q;

  // only one deferred request can be held
  a_no_req_while_pending: assert property (
    @(posedge clk_i) disable iff (reset_i) pend_q |-> !dbg_req_valid_i
  );

endmodule

`default_nettype wire

// File: verilog/l2_mem.sv
// L2 memory model with byte strobes and one cycle read latency, sits behind soc_bus
`include "soc_config.svh"
`timescale 1ns/1ps
`default_nettype none

module l2_mem (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_valid_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::data_t    rdata_o,
  output logic                  rvalid_o
);

  localparam int unsigned N_BYTES = `SOC_DATA_W / 8;
  localparam int unsigned OFF_W   = $clog2(N_BYTES);
  localparam int unsigned IDX_W   = $clog2(`SOC_L2_WORDS);

  soc_bus_pkg::data_t mem_q [`SOC_L2_WORDS];
  soc_bus_pkg::data_t rdata_q;
  logic               rvalid_q;
  logic [IDX_W-1:0]   idx;

  // word index, byte offset bits dropped
  assign idx = req_i.addr[OFF_W +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_i.write) begin
      for (int b = 0; b < N_BYTES; b++) begin
        if (req_i.strb[b]) mem_q[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && !req_i.write) rdata_q <= mem_q[idx];
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_valid_i && !req_i.write;
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// File: verilog/run_timer.sv
// Cluster run timer, loaded at run start and pulsing once when the run is over
`include "soc_config.svh"
`timescale 1ns/1ps
`default_nettype none

module run_timer (
  input  logic clk_i,
  input  logic reset_i,
  input  logic load_i,
  output logic expired_o
);

  localparam soc_ctrl_pkg::run_cnt_t CNT_INIT = soc_ctrl_pkg::run_cnt_t'(`SOC_CL_RUN_CYCLES - 1);

  soc_ctrl_pkg::run_cnt_t cnt_q;
  logic                   active_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
    end else if (load_i) begin
      cnt_q    <= CNT_INIT;
      active_q <= 1'b1;
    end else if (active_q) begin
      // park at zero once the pulse is out
      if (cnt_q == '0) active_q <= 1'b0;
      else cnt_q <= cnt_q - 1'b1;
    end
  end

  assign expired_o = active_q && (cnt_q == '0);

endmodule

`default_nettype wire

// File: verilog/soc_bus.sv
// SoC bus in front of L2, host has fixed priority over the debug port
`timescale 1ns/1ps
`default_nettype none

module soc_bus (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  host_req_valid_i,
  input  soc_bus_pkg::bus_req_t host_req_i,
  input  logic                  dbg_req_valid_i,
  input  soc_bus_pkg::bus_req_t dbg_req_i,
  input  soc_bus_pkg::data_t    mem_rdata_i,
  input  logic                  mem_rvalid_i,
  output logic                  mem_req_valid_o,
  output soc_bus_pkg::bus_req_t mem_req_o,
  output logic                  dbg_served_o,
  output soc_bus_pkg::data_t    host_rdata_o,
  output logic                  host_rvalid_o,
  output soc_bus_pkg::data_t    dbg_rdata_o,
  output logic                  dbg_rvalid_o
);

  // owner of the read in flight, high for debug
  logic owner_dbg_q;

  // host always wins
  assign mem_req_valid_o = host_req_valid_i | dbg_req_valid_i;
  assign mem_req_o       = host_req_valid_i ? host_req_i : dbg_req_i;
  assign dbg_served_o    = dbg_req_valid_i & ~host_req_valid_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner_dbg_q <= 1'b0;
    end else if (mem_req_valid_o && !mem_req_o.write) begin
      owner_dbg_q <= ~host_req_valid_i;
    end
  end

  // memory read data is shared, the strobe is steered
  assign host_rdata_o  = mem_rdata_i;
  assign dbg_rdata_o   = mem_rdata_i;
  assign host_rvalid_o = mem_rvalid_i & ~owner_dbg_q;
  assign dbg_rvalid_o  = mem_rvalid_i & owner_dbg_q;

  a_one_rvalid: assert property (
    @(posedge clk_i) disable iff (reset_i) !(host_rvalid_o && dbg_rvalid_o)
  );

  // every returned read belongs to a read granted the cycle before
  a_rvalid_follows_read: assert property (
    @(posedge clk_i) disable iff (reset_i)
      mem_rvalid_i |-> $past(mem_req_valid_o && !mem_req_o.write)
  );

endmodule

`default_nettype wire

// File: verilog/soc_bus_pkg.sv
// Data path types shared by the upsizer, the SoC bus, the L2 memory and the top level
`default_nettype none

`include "soc_config.svh"

package soc_bus_pkg;

  typedef logic [`SOC_ADDR_W-1:0]     addr_t;
  typedef logic [`SOC_DATA_W-1:0]     data_t;
  typedef logic [`SOC_DATA_W/8-1:0]   strb_t;
  typedef logic [`SOC_NARROW_W-1:0]   narrow_data_t;

  // full width request as seen by the bus and the memory
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
    strb_t strb;
  } bus_req_t;

  // debug side request, no strobes, lane follows the address
  typedef struct packed {
    logic         write;
    addr_t        addr;
    narrow_data_t data;
  } narrow_req_t;

endpackage

`default_nettype wire

// File: verilog/soc_config.svh
// SoC sizing macros for memory depth, bus widths and cluster run length; include where needed
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// L2 depth in 64-bit words
`define SOC_L2_WORDS 256

// byte address width, covers the whole L2
`define SOC_ADDR_W 11

// bus widths
`define SOC_DATA_W 64
`define SOC_NARROW_W 32

// cluster stand-in run length in cycles
`define SOC_CL_RUN_CYCLES 20
`define SOC_RUN_CNT_W 5

`endif

// File: verilog/soc_ctrl_pkg.sv
// Cluster control types for the run state machine and its timer
`default_nettype none

`include "soc_config.svh"

package soc_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } cl_state_e;

  typedef logic [`SOC_RUN_CNT_W-1:0] run_cnt_t;

endpackage

`default_nettype wire

// File: verilog/soc_top.sv
// SoC top level joining host and debug data paths to L2 and the cluster control stand-in
`timescale 1ns/1ps
`default_nettype none

module soc_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      host_req_valid_i,
  input  soc_bus_pkg::bus_req_t     host_req_i,
  output soc_bus_pkg::data_t        host_rdata_o,
  output logic                      host_rvalid_o,
  input  logic                      dbg_req_valid_i,
  input  soc_bus_pkg::narrow_req_t  dbg_req_i,
  output soc_bus_pkg::narrow_data_t dbg_rdata_o,
  output logic                      dbg_rvalid_o,
  input  logic                      cl_fetch_en_i,
  output logic                      cl_busy_o,
  output logic                      cl_eoc_o
);

  // upsizer to bus
  logic                  dbg_wide_valid;
  soc_bus_pkg::bus_req_t dbg_wide_req;
  logic                  dbg_served;
  soc_bus_pkg::data_t    dbg_wide_rdata;
  logic                  dbg_wide_rvalid;

  // bus to L2
  logic                  mem_req_valid;
  soc_bus_pkg::bus_req_t mem_req;
  soc_bus_pkg::data_t    mem_rdata;
  logic                  mem_rvalid;

  // cluster control
  logic                  timer_load;
  logic                  timer_expired;

  dw_upsizer i_dwc_debug (
    .clk_i,
    .reset_i,
    .dbg_req_valid_i,
    .dbg_req_i,
    .served_i     (dbg_served),
    .rdata_i      (dbg_wide_rdata),
    .rvalid_i     (dbg_wide_rvalid),
    .req_valid_o  (dbg_wide_valid),
    .req_o        (dbg_wide_req),
    .dbg_rdata_o,
    .dbg_rvalid_o
  );

  soc_bus i_soc_bus (
    .clk_i,
    .reset_i,
    .host_req_valid_i,
    .host_req_i,
    .dbg_req_valid_i  (dbg_wide_valid),
    .dbg_req_i        (dbg_wide_req),
    .mem_rdata_i      (mem_rdata),
    .mem_rvalid_i     (mem_rvalid),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_o        (mem_req),
    .dbg_served_o     (dbg_served),
    .host_rdata_o,
    .host_rvalid_o,
    .dbg_rdata_o      (dbg_wide_rdata),
    .dbg_rvalid_o     (dbg_wide_rvalid)
  );

  l2_mem i_l2_mem (
    .clk_i,
    .reset_i,
    .req_valid_i  (mem_req_valid),
    .req_i        (mem_req),
    .rdata_o      (mem_rdata),
    .rvalid_o     (mem_rvalid)
  );

  cluster_fsm i_cluster_fsm (
    .clk_i,
    .reset_i,
    .fetch_en_i   (cl_fetch_en_i),
    .expired_i    (timer_expired),
    .timer_load_o (timer_load),
    .busy_o       (cl_busy_o),
    .eoc_o        (cl_eoc_o)
  );

  run_timer i_run_timer (
    .clk_i,
    .reset_i,
    .load_i       (timer_load),
    .expired_o    (timer_expired)
  );

endmodule

`default_nettype wire
